/* include/transform_defines.svh */
`ifndef TRANSFORM_DEFINES_SVH
`define TRANSFORM_DEFINES_SVH

// Fixed-point formats.
`define DATAWIDTH 24
`define FRACBITS 13
`define PIXELWIDTH 12
`define DEPTH_FRACBITS 11

// Viewport in pixels.
`define SCREEN_WIDTH 320
`define SCREEN_HEIGHT 320

// Clip-space vertices buffered between shader and post-processor.
`define FIFO_DEPTH 8

`endif

/* rtl/vertex_pkg.sv */
package vertex_pkg;

`include "transform_defines.svh"

    typedef logic signed [`DATAWIDTH-1:0] coord_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
        coord_t z;
    } obj_vertex_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
        coord_t z;
        coord_t w;
    } clip_vertex_t;

    // Element [4*row+col], element 0 in the low bits.
    typedef coord_t [15:0] mvp_matrix_t;

    typedef struct packed {
        logic signed [`PIXELWIDTH-1:0] px;
        logic signed [`PIXELWIDTH-1:0] py;
        logic [`DEPTH_FRACBITS:0] depth; // Unsigned, range 0 to 1.0.
    } screen_vertex_t;

endpackage

/* rtl/pipeline_ctrl_pkg.sv */
package pipeline_ctrl_pkg;

    // Vertex shader.
    typedef enum logic {
        SH_IDLE = 1'b0,
        SH_ROW  = 1'b1
    } shader_state_t;

    // Vertex post-processor.
    typedef enum logic [1:0] {
        VPP_IDLE   = 2'd0,
        VPP_DIVIDE = 2'd1,
        VPP_MAP    = 2'd2,
        VPP_DONE   = 2'd3
    } vpp_state_t;

endpackage

/* rtl/vertex_shader.sv */
`timescale 1ns/1ps

`include "transform_defines.svh"

module vertex_shader (
    input  logic                     clk,
    input  logic                     rstn,
    input  vertex_pkg::mvp_matrix_t  i_mvp,
    input  logic                     i_mvp_dv,
    input  vertex_pkg::obj_vertex_t  i_vertex,
    input  logic                     i_vertex_dv,
    input  logic                     i_vertex_last,
    input  logic                     i_fifo_full,
    output logic                     o_ready,
    output vertex_pkg::clip_vertex_t o_vertex,
    output logic                     o_vertex_dv,
    output logic                     o_finished
);
    import vertex_pkg::*;
    import pipeline_ctrl_pkg::*;

    localparam coord_t ONE = coord_t'(1 << `FRACBITS);

    shader_state_t state;
    logic [1:0] row_q;
    logic armed_q;
    logic last_q;
    logic accept;
    mvp_matrix_t mvp_q;
    obj_vertex_t vtx_q;
    coord_t operand [4];
    logic signed [2*`DATAWIDTH-1:0] prod [4];
    logic signed [2*`DATAWIDTH+1:0] acc;
    coord_t comp;

    // Pending write must land before the next vertex is taken.
    assign o_ready = armed_q && (state == SH_IDLE) && !i_fifo_full && !o_vertex_dv;
    assign accept = i_vertex_dv && o_ready;

    assign operand[0] = vtx_q.x;
    assign operand[1] = vtx_q.y;
    assign operand[2] = vtx_q.z;
    assign operand[3] = ONE; // Homogeneous w.

    always_comb begin
        acc = '0;
        for (int j = 0; j < 4; j++) begin
            prod[j] = $signed(mvp_q[4*row_q + j]) * $signed(operand[j]);
            acc = acc + prod[j];
        end
    end

    assign comp = acc[`FRACBITS +: `DATAWIDTH]; // Drop fraction, truncate.

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= SH_IDLE;
            row_q <= '0;
            armed_q <= 1'b0;
            o_vertex_dv <= 1'b0;
            o_finished <= 1'b0;
        end else begin
            armed_q <= 1'b1;
            o_vertex_dv <= 1'b0;
            o_finished <= 1'b0;
            case (state)
                SH_IDLE: begin
                    if (accept) begin
                        state <= SH_ROW;
                        row_q <= '0;
                    end
                end
                SH_ROW: begin
                    row_q <= row_q + 1'b1;
                    if (row_q == 2'd3) begin
                        state <= SH_IDLE;
                        o_vertex_dv <= 1'b1;
                        o_finished <= last_q;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (i_mvp_dv && state == SH_IDLE) begin
            mvp_q <= i_mvp;
        end
        if (accept) begin
            vtx_q <= i_vertex;
            last_q <= i_vertex_last;
        end
        if (state == SH_ROW) begin
            case (row_q)
                2'd0: o_vertex.x <= comp;
                2'd1: o_vertex.y <= comp;
                2'd2: o_vertex.z <= comp;
                2'd3: o_vertex.w <= comp;
            endcase
        end
    end

    // Results are spaced by the four row cycles.
    a_dv_spacing: assert property (@(posedge clk) disable iff (!rstn)
        o_vertex_dv |=> !o_vertex_dv);

endmodule

/* rtl/vertex_fifo.sv */
`timescale 1ns/1ps

`include "transform_defines.svh"

module vertex_fifo (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     i_wr_en,
    input  vertex_pkg::clip_vertex_t i_wr_data,
    input  logic                     i_rd_en,
    output vertex_pkg::clip_vertex_t o_rd_data,
    output logic                     o_dv,
    output logic                     o_empty,
    output logic                     o_full
);
    import vertex_pkg::*;

    localparam int AW = $clog2(`FIFO_DEPTH);
    localparam logic [AW-1:0] LAST_PTR = AW'(`FIFO_DEPTH - 1);
    localparam logic [AW:0] FULL_COUNT = (AW+1)'(`FIFO_DEPTH);

    clip_vertex_t mem [`FIFO_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0] count;

    assign o_empty = (count == '0);
    assign o_full = (count == FULL_COUNT);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            o_dv <= 1'b0;
        end else begin
            o_dv <= i_rd_en; // Data follows the request by one cycle.
            if (i_wr_en) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (i_rd_en) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            case ({i_wr_en, i_rd_en})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (i_wr_en) begin
            mem[wr_ptr] <= i_wr_data;
        end
        if (i_rd_en) begin
            o_rd_data <= mem[rd_ptr];
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (!rstn) i_wr_en |-> !o_full);
    a_no_underflow: assert property (@(posedge clk) disable iff (!rstn) i_rd_en |-> !o_empty);

endmodule

/* rtl/vertex_post_processor.sv */
`timescale 1ns/1ps

`include "transform_defines.svh"

module vertex_post_processor (
    input  logic                       clk,
    input  logic                       rstn,
    input  vertex_pkg::clip_vertex_t   i_vertex,
    input  logic                       i_vertex_dv,
    output logic                       o_ready,
    output vertex_pkg::screen_vertex_t o_vertex,
    output logic                       o_dv,
    output logic                       o_invalid
);
    import vertex_pkg::*;
    import pipeline_ctrl_pkg::*;

    localparam int DW = `DATAWIDTH;
    localparam int SHIFT_HI = `DATAWIDTH - `FRACBITS;
    localparam int DEPTH_SHIFT = `FRACBITS - `DEPTH_FRACBITS + 1;
    localparam coord_t ONE = coord_t'(1 << `FRACBITS);
    localparam logic signed [`PIXELWIDTH-1:0] HALF_W = `PIXELWIDTH'(`SCREEN_WIDTH / 2);
    localparam logic signed [`PIXELWIDTH-1:0] HALF_H = `PIXELWIDTH'(`SCREEN_HEIGHT / 2);

    vpp_state_t state;
    clip_vertex_t vtx_q;
    coord_t ndc_q [3];
    logic [1:0] comp_idx;
    logic [4:0] bit_cnt;
    logic [DW-1:0] rem_q;
    logic [DW-1:0] dvd_q;
    logic [DW-1:0] quo_q;
    logic invalid_q;
    logic div_load;
    logic div_last;

    coord_t num;
    logic [DW-1:0] mag;
    logic [DW:0] trial;
    logic [DW-1:0] rem_next;
    logic [DW-1:0] quo_next;
    logic signed [DW:0] sum_x;
    logic signed [DW:0] sum_y;
    logic signed [DW:0] sum_z;
    logic signed [DW+`PIXELWIDTH:0] map_x;
    logic signed [DW+`PIXELWIDTH:0] map_y;

    assign o_ready = (state == VPP_IDLE);
    assign o_dv = (state == VPP_DONE);
    assign o_invalid = invalid_q;

    // Cycle 0 of a component loads the divider, then 24 quotient bits.
    assign div_load = (state == VPP_DIVIDE) && (bit_cnt == '0);
    assign div_last = (state == VPP_DIVIDE) && (bit_cnt == 5'(DW));

    always_comb begin
        case (comp_idx)
            2'd0: num = vtx_q.x;
            2'd1: num = vtx_q.y;
            default: num = vtx_q.z;
        endcase
        mag = num[DW-1] ? ~num + 1'b1 : num;
        trial = {rem_q, dvd_q[DW-1]} - {1'b0, vtx_q.w};
        rem_next = trial[DW] ? {rem_q[DW-2:0], dvd_q[DW-1]} : trial[DW-1:0];
        quo_next = {quo_q[DW-2:0], ~trial[DW]};
    end

    assign sum_x = ndc_q[0] + ONE;
    assign sum_y = ONE - ndc_q[1]; // Screen y grows downward.
    assign sum_z = ndc_q[2] + ONE;
    assign map_x = sum_x * HALF_W;
    assign map_y = sum_y * HALF_H;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= VPP_IDLE;
            comp_idx <= '0;
            bit_cnt <= '0;
            invalid_q <= 1'b0;
        end else begin
            case (state)
                VPP_IDLE: begin
                    if (i_vertex_dv) begin
                        comp_idx <= '0;
                        bit_cnt <= '0;
                        if ($signed(i_vertex.w) <= 0) begin
                            invalid_q <= 1'b1; // Behind the eye, no divide.
                            state <= VPP_DONE;
                        end else begin
                            invalid_q <= 1'b0;
                            state <= VPP_DIVIDE;
                        end
                    end
                end
                VPP_DIVIDE: begin
                    // Upper dividend half not below w means quotient beyond 24 bits.
                    if (div_load && (mag >> SHIFT_HI) >= vtx_q.w) begin
                        invalid_q <= 1'b1;
                    end
                    if (div_last && quo_next > ONE) begin
                        invalid_q <= 1'b1;
                    end
                    if (div_last) begin
                        bit_cnt <= '0;
                        if (comp_idx == 2'd2) begin
                            state <= VPP_MAP;
                        end else begin
                            comp_idx <= comp_idx + 1'b1;
                        end
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                VPP_MAP: state <= VPP_DONE;
                VPP_DONE: state <= VPP_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (o_ready && i_vertex_dv) begin
            vtx_q <= i_vertex;
        end
        if (div_load) begin
            rem_q <= mag >> SHIFT_HI;
            dvd_q <= mag << `FRACBITS;
            quo_q <= '0;
        end else if (state == VPP_DIVIDE) begin
            rem_q <= rem_next;
            dvd_q <= dvd_q << 1;
            quo_q <= quo_next;
        end
        if (div_last) begin
            ndc_q[comp_idx] <= num[DW-1] ? -quo_next : quo_next; // Truncated toward zero.
        end
        if (state == VPP_MAP) begin
            o_vertex.px <= map_x[`FRACBITS +: `PIXELWIDTH];
            o_vertex.py <= map_y[`FRACBITS +: `PIXELWIDTH];
            o_vertex.depth <= sum_z[DEPTH_SHIFT +: `DEPTH_FRACBITS+1];
        end
    end

    // FIFO read must wait for ready, not just the data valid.
    a_dv_when_ready: assert property (@(posedge clk) disable iff (!rstn)
        i_vertex_dv |-> o_ready);

endmodule

/* rtl/transform_pipeline.sv */
`timescale 1ns/1ps

module transform_pipeline (
    input  logic                       clk,
    input  logic                       rstn,
    input  vertex_pkg::mvp_matrix_t    i_mvp,
    input  logic                       i_mvp_dv,
    input  vertex_pkg::obj_vertex_t    i_vertex,
    input  logic                       i_vertex_dv,
    input  logic                       i_vertex_last,
    output logic                       o_ready,
    output logic                       o_finished,
    output vertex_pkg::clip_vertex_t   o_vs_vertex,
    output logic                       o_vs_vertex_dv,
    output vertex_pkg::screen_vertex_t o_vertex,
    output logic                       o_vertex_dv,
    output logic                       o_vpp_error
);
    import vertex_pkg::*;

    clip_vertex_t vs_vertex;
    logic vs_vertex_dv;
    clip_vertex_t fifo_data;
    logic fifo_dv;
    logic fifo_rd_en;
    logic fifo_empty;
    logic fifo_full;
    screen_vertex_t vpp_vertex;
    logic vpp_dv;
    logic vpp_invalid;
    logic vpp_ready;

    vertex_shader vs0 (
        .clk(clk),
        .rstn(rstn),
        .i_mvp(i_mvp),
        .i_mvp_dv(i_mvp_dv),
        .i_vertex(i_vertex),
        .i_vertex_dv(i_vertex_dv),
        .i_vertex_last(i_vertex_last),
        .i_fifo_full(fifo_full),
        .o_ready(o_ready),
        .o_vertex(vs_vertex),
        .o_vertex_dv(vs_vertex_dv),
        .o_finished(o_finished)
    );

    vertex_fifo fifo0 (
        .clk(clk),
        .rstn(rstn),
        .i_wr_en(vs_vertex_dv),
        .i_wr_data(vs_vertex),
        .i_rd_en(fifo_rd_en),
        .o_rd_data(fifo_data),
        .o_dv(fifo_dv),
        .o_empty(fifo_empty),
        .o_full(fifo_full)
    );

    // No new request while a read is still in flight.
    assign fifo_rd_en = vpp_ready && !fifo_empty && !fifo_dv;

    vertex_post_processor vpp0 (
        .clk(clk),
        .rstn(rstn),
        .i_vertex(fifo_data),
        .i_vertex_dv(fifo_dv),
        .o_ready(vpp_ready),
        .o_vertex(vpp_vertex),
        .o_dv(vpp_dv),
        .o_invalid(vpp_invalid)
    );

    assign o_vs_vertex = fifo_data;
    assign o_vs_vertex_dv = fifo_dv;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            o_vertex_dv <= 1'b0;
            o_vpp_error <= 1'b0;
        end else begin
            o_vertex_dv <= vpp_dv && !vpp_invalid;
            o_vpp_error <= vpp_dv && vpp_invalid;
        end
    end

    always_ff @(posedge clk) begin
        if (vpp_dv && !vpp_invalid) begin
            o_vertex <= vpp_vertex;
        end
    end

endmodule

/* testbench/tb_transform_pipeline.sv */
`timescale 1ns/1ps

`include "transform_defines.svh"

module tb_transform_pipeline;
    import vertex_pkg::*;

    localparam longint ONE = 1 << `FRACBITS;
    localparam int TIMEOUT = 4000;
    localparam int BURST_LEN = 2 * `FIFO_DEPTH + 4;

    typedef struct packed {
        clip_vertex_t clip;
        logic valid;
        screen_vertex_t scr;
    } expect_t;

    logic clk;
    logic rstn;
    mvp_matrix_t i_mvp;
    logic i_mvp_dv;
    obj_vertex_t i_vertex;
    logic i_vertex_dv;
    logic i_vertex_last;
    logic o_ready;
    logic o_finished;
    clip_vertex_t o_vs_vertex;
    logic o_vs_vertex_dv;
    screen_vertex_t o_vertex;
    logic o_vertex_dv;
    logic o_vpp_error;

    mvp_matrix_t cur_mvp;
    logic [31:0] lfsr;
    string test_name;
    clip_vertex_t clip_q [$];
    expect_t res_q [$];
    int finished_count;
    int result_count;

    transform_pipeline dut0 (.*);

    initial clk = 1'b0;
    always #50 clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // Taps 32, 22, 2, 1.
    endfunction

    // n LFSR bits as a sign-extended value.
    function automatic coord_t random_signed(input int n);
        logic signed [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            r = {r[30:0], lfsr[0]};
        end
        r = r <<< (32 - n);
        return coord_t'(r >>> (32 - n));
    endfunction

    function automatic mvp_matrix_t random_projection();
        mvp_matrix_t m;
        for (int i = 0; i < 12; i++) begin
            m[i] = (i % 5 == 0) ? coord_t'(3 * ONE / 4) + random_signed(11) : random_signed(11);
        end
        m[12] = '0;
        m[13] = '0;
        m[14] = random_signed(11);
        m[15] = coord_t'(ONE + ONE / 4) + random_signed(12); // w around 1.25.
        return m;
    endfunction

    function automatic expect_t reference_model(input mvp_matrix_t m, input obj_vertex_t v);
        longint op [4];
        longint comp [4];
        longint ndc [3];
        longint acc;
        longint mag;
        longint q;
        longint px;
        longint py;
        longint depth;
        expect_t e;
        op = '{longint'(v.x), longint'(v.y), longint'(v.z), ONE};
        for (int r = 0; r < 4; r++) begin
            acc = 0;
            for (int j = 0; j < 4; j++) begin
                acc += longint'(coord_t'(m[4*r + j])) * op[j];
            end
            comp[r] = longint'(coord_t'(acc >>> `FRACBITS)); // Wraps to 24 bits.
        end
        e.clip = '{x: coord_t'(comp[0]), y: coord_t'(comp[1]),
                   z: coord_t'(comp[2]), w: coord_t'(comp[3])};
        e.valid = comp[3] > 0;
        for (int i = 0; i < 3; i++) begin
            mag = (comp[i] < 0) ? -comp[i] : comp[i];
            q = (comp[3] > 0) ? (mag <<< `FRACBITS) / comp[3] : 0;
            if (q > ONE) begin
                e.valid = 1'b0;
            end
            ndc[i] = (comp[i] < 0) ? -q : q;
        end
        px = ((ndc[0] + ONE) * (`SCREEN_WIDTH / 2)) >>> `FRACBITS;
        py = ((ONE - ndc[1]) * (`SCREEN_HEIGHT / 2)) >>> `FRACBITS;
        depth = ((ndc[2] + ONE) >>> 1) >>> (`FRACBITS - `DEPTH_FRACBITS);
        e.scr.px = px[`PIXELWIDTH-1:0];
        e.scr.py = py[`PIXELWIDTH-1:0];
        e.scr.depth = depth[`DEPTH_FRACBITS:0];
        return e;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input string what, input logic [95:0] expected,
                               input logic [95:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED %s: %s expected %h actual %h",
                     test_name, what, expected, actual);
            abort_run("a compared value differs from the reference");
        end
    endtask

    task automatic load_matrix(input mvp_matrix_t m);
        cur_mvp = m;
        i_mvp = m;
        i_mvp_dv = 1'b1;
        @(negedge clk);
        i_mvp_dv = 1'b0;
    endtask

    task automatic send_vertex(input longint x, input longint y, input longint z,
                               input logic last, output int waited);
        obj_vertex_t v;
        expect_t e;
        v = '{x: coord_t'(x), y: coord_t'(y), z: coord_t'(z)};
        waited = 0;
        while (!o_ready && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!o_ready) begin
            abort_run("o_ready did not rise before the timeout");
        end
        e = reference_model(cur_mvp, v);
        clip_q.push_back(e.clip);
        res_q.push_back(e);
        i_vertex = v;
        i_vertex_last = last;
        i_vertex_dv = 1'b1;
        @(negedge clk);
        i_vertex_dv = 1'b0;
        i_vertex_last = 1'b0;
    endtask

    task automatic drain_results();
        int cycles;
        cycles = 0;
        while ((clip_q.size() > 0 || res_q.size() > 0) && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (clip_q.size() > 0 || res_q.size() > 0) begin
            abort_run("the pipeline did not return every accepted vertex in time");
        end
    endtask

    // Outputs settle after the rising edge, so they are read mid-cycle.
    always @(negedge clk) begin : monitor
        expect_t e;
        clip_vertex_t c;
        if (rstn) begin
            if (o_finished) begin
                finished_count++;
            end
            if (o_vs_vertex_dv) begin
                if (clip_q.size() == 0) begin
                    abort_run("a clip vertex arrived with none expected");
                end
                c = clip_q.pop_front();
                check_value("clip vertex", c, o_vs_vertex);
            end
            if (o_vertex_dv && o_vpp_error) begin
                abort_run("a result was flagged both accepted and rejected");
            end
            if (o_vertex_dv || o_vpp_error) begin
                if (res_q.size() == 0) begin
                    abort_run("a screen result arrived with none expected");
                end
                e = res_q.pop_front();
                result_count++;
                check_value("accepted flag", e.valid, o_vertex_dv);
                if (e.valid) begin
                    check_value("screen vertex", e.scr, o_vertex);
                end
            end
        end
    end

    initial begin
        mvp_matrix_t ident;
        coord_t rx;
        coord_t ry;
        coord_t rz;
        int waited;
        int max_wait;
        lfsr = 32'hdbfe;
        rstn = 1'b0;
        i_mvp = '0;
        i_mvp_dv = 1'b0;
        i_vertex = '0;
        i_vertex_dv = 1'b0;
        i_vertex_last = 1'b0;
        cur_mvp = '0;
        finished_count = 0;
        result_count = 0;
        test_name = "reset";
        repeat (8) @(negedge clk);
        check_value("o_ready during reset", 0, o_ready);
        rstn = 1'b1;
        @(negedge clk);
        check_value("o_ready", 1, o_ready);
        check_value("strobes", 0, {o_vertex_dv, o_vs_vertex_dv, o_vpp_error, o_finished});

        test_name = "identity";
        ident = '0;
        for (int i = 0; i < 4; i++) begin
            ident[5*i] = coord_t'(ONE);
        end
        load_matrix(ident);
        send_vertex(0, 0, 0, 1'b0, waited);
        send_vertex(-ONE, -ONE, -ONE, 1'b0, waited); // Corner (-1, -1).
        send_vertex(ONE, ONE, ONE, 1'b0, waited);
        send_vertex(ONE / 2, -ONE / 4, 3 * ONE / 4, 1'b0, waited);
        drain_results();

        test_name = "random";
        load_matrix(random_projection());
        for (int i = 0; i < 24; i++) begin
            rx = random_signed(14);
            ry = random_signed(14);
            rz = random_signed(14);
            send_vertex(rx, ry, rz, 1'b0, waited);
        end
        drain_results();

        test_name = "rejection";
        ident[14] = coord_t'(ONE);
        ident[15] = '0; // w follows z.
        load_matrix(ident);
        send_vertex(ONE / 4, ONE / 4, 0, 1'b0, waited);
        send_vertex(ONE / 4, 0, -ONE / 2, 1'b0, waited);
        send_vertex(ONE / 4, -ONE / 4, ONE / 2, 1'b0, waited);
        send_vertex(ONE, 0, ONE / 4, 1'b0, waited); // x four times w.
        send_vertex(-ONE, 0, 1, 1'b0, waited);
        send_vertex(0, ONE / 2, ONE, 1'b0, waited);
        send_vertex(-ONE / 8, ONE / 8, ONE / 4, 1'b0, waited);
        drain_results();

        test_name = "burst";
        load_matrix(random_projection());
        finished_count = 0;
        result_count = 0;
        max_wait = 0;
        for (int i = 0; i < BURST_LEN; i++) begin
            rx = random_signed(14);
            ry = random_signed(14);
            rz = random_signed(14);
            send_vertex(rx, ry, rz, i == BURST_LEN - 1, waited);
            if (waited > max_wait) begin
                max_wait = waited;
            end
        end
        drain_results();
        check_value("o_ready held low by a full FIFO", 1, max_wait > 10);
        check_value("result count", BURST_LEN, result_count);
        check_value("o_finished pulses", 1, finished_count);

        test_name = "end";
        if (clip_q.size() == 0 && res_q.size() == 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            abort_run("expected results were left over at the end");
        end
    end

endmodule

/* all.f */
+incdir+include
rtl/vertex_pkg.sv
rtl/pipeline_ctrl_pkg.sv
rtl/vertex_shader.sv
rtl/vertex_fifo.sv
rtl/vertex_post_processor.sv
rtl/transform_pipeline.sv
testbench/tb_transform_pipeline.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_transform_pipeline -f all.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_tb 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Verification passed"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
